// File: include/render_cfg.svh
/*
 * battlefield renderer configuration
 * screen bands, sprite geometry, object count, colours and pipeline depth
 */
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

`define RENDER_NUM_OBJECTS        4     // slots 0-1 army, 2-3 enemy
`define RENDER_COORD_W            10

// visible raster, everything beyond is blanking
`define RENDER_H_ACTIVE           640
`define RENDER_V_ACTIVE           480

`define RENDER_GRASS_TOP          140
`define RENDER_PATH_TOP           170
`define RENDER_PATH_BOTTOM        230
`define RENDER_FIELD_BOTTOM       270   // board from here down

`define RENDER_COLOUR_SKY         12'h2bf
`define RENDER_COLOUR_GRASS       12'h5b2
`define RENDER_COLOUR_PATH        12'hda5
`define RENDER_COLOUR_BOARD       12'hfb7
`define RENDER_COLOUR_LIGHT       12'hfff
`define RENDER_COLOUR_ACCENT      12'hf00
`define RENDER_COLOUR_DARK        12'h000

`define RENDER_ROM_DEPTH          64    // bytes, four texels each
`define RENDER_SPRITE_SCALE_SHIFT 1     // 2x2 screen pixels per texel
`define RENDER_PIPE_LATENCY       3

`endif

// File: logic/render_pkg.sv
/*
 * renderer types: object descriptor, lane result, texel and colour codes,
 * plus the per-kind sprite geometry lookup
 */
`include "render_cfg.svh"

package render_pkg;

    typedef logic [`RENDER_COORD_W-1:0]           coord_t;
    typedef logic [11:0]                          colour_t;
    typedef logic [1:0]                           texel_t;
    typedef logic [2:0]                           sprite_kind_t;
    typedef logic [$clog2(`RENDER_ROM_DEPTH)-1:0] rom_addr_t;

    localparam texel_t TEXEL_LIGHT  = 2'd0;
    localparam texel_t TEXEL_DARK   = 2'd1;
    localparam texel_t TEXEL_ACCENT = 2'd2;
    localparam texel_t TEXEL_CLEAR  = 2'd3;  // transparent

    typedef struct packed {
        logic         exists;
        sprite_kind_t kind;
        coord_t       x;
        coord_t       y;
        logic [3:0]   state;   // bit 0 picks the animation frame
    } object_t;

    typedef struct packed {
        logic   hit;
        texel_t texel;
    } lane_result_t;

    typedef struct packed {
        rom_addr_t  base;
        logic [3:0] width;     // in texels
        logic [3:0] height;
    } sprite_geom_t;

    // zero width means the kind is never drawn
    function automatic sprite_geom_t sprite_geometry(input sprite_kind_t kind);
        sprite_geom_t geom;
        case (kind)
            3'd0:    geom = '{base: rom_addr_t'(0),  width: 4'd8, height: 4'd8};
            3'd1:    geom = '{base: rom_addr_t'(32), width: 4'd8, height: 4'd4};
            default: geom = '{base: rom_addr_t'(0),  width: 4'd0, height: 4'd0};
        endcase
        return geom;
    endfunction

endpackage

// File: logic/object_table.sv
/*
 * object table
 * holds the descriptors, written by the game logic over a four-phase req/ack
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module object_table import render_pkg::*; (
    input  logic                                  clk_25MHz,
    input  logic                                  arst_n,
    input  logic                                  obj_req,
    input  logic [$clog2(`RENDER_NUM_OBJECTS)-1:0] obj_index,
    input  object_t                               obj_data,
    output logic                                  obj_ack,
    output object_t                               objects [`RENDER_NUM_OBJECTS]
);

    object_t                        entry_q  [`RENDER_NUM_OBJECTS];
    logic [`RENDER_NUM_OBJECTS-1:0] exists_q;
    logic                           wr_en;

    // new request seen while idle
    assign wr_en = obj_req && !obj_ack;

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            obj_ack <= 1'b0;
        end else if (wr_en) begin
            obj_ack <= 1'b1;
        end else if (obj_ack && !obj_req) begin
            obj_ack <= 1'b0;   // host released req
        end
    end

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            exists_q <= '0;
        end else if (wr_en) begin
            exists_q[obj_index] <= obj_data.exists;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (wr_en) begin
            entry_q[obj_index] <= obj_data;
        end
    end

    always_comb begin
        for (int i = 0; i < `RENDER_NUM_OBJECTS; i++) begin
            objects[i]        = entry_q[i];
            objects[i].exists = exists_q[i];
        end
    end

endmodule

// File: logic/sprite_rom.sv
/*
 * sprite ROM
 * byte wide, four 2-bit texels per byte, registered read
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module sprite_rom import render_pkg::*; (
    input  logic      clk_25MHz,
    input  rom_addr_t addr,
    output logic [7:0] data
);

    logic [7:0] mem [`RENDER_ROM_DEPTH];

    initial begin
        $readmemh("sprites.mem", mem);
    end

    always_ff @(posedge clk_25MHz) begin
        data <= mem[addr];
    end

endmodule

// File: logic/sprite_lane.sv
/*
 * sprite lane
 * one object: origin offset, bounds test, ROM address and texel select.
 * result is valid two clocks after the coordinate
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module sprite_lane import render_pkg::*; (
    input  logic         clk_25MHz,
    input  logic         arst_n,
    input  coord_t       h_cnt,
    input  coord_t       v_cnt,
    input  object_t      object,
    output lane_result_t result
);

    sprite_geom_t geom;
    coord_t       dx;
    coord_t       dy;
    logic [7:0]   tx;
    logic [7:0]   ty;
    logic [7:0]   frame_off;
    logic [7:0]   texel_index;
    logic         in_bounds;
    rom_addr_t    addr_q;
    logic [1:0]   sel_q;
    logic [1:0]   sel_q2;
    logic         in_bounds_q;
    logic         in_bounds_q2;
    logic [7:0]   rom_data;
    texel_t       texel;

    always_comb begin
        geom = sprite_geometry(object.kind);
        dx   = h_cnt - object.x;   // left of origin wraps large
        dy   = v_cnt - object.y;
        tx   = 8'(dx >> `RENDER_SPRITE_SCALE_SHIFT);
        ty   = 8'(dy >> `RENDER_SPRITE_SCALE_SHIFT);

        in_bounds = object.exists
                 && (dx < (coord_t'(geom.width)  << `RENDER_SPRITE_SCALE_SHIFT))
                 && (dy < (coord_t'(geom.height) << `RENDER_SPRITE_SCALE_SHIFT));

        frame_off   = object.state[0] ? 8'(geom.width * geom.height) : 8'd0;
        texel_index = ty * 8'(geom.width) + tx + frame_off;
    end

    // stage 1
    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            in_bounds_q  <= 1'b0;
            in_bounds_q2 <= 1'b0;
        end else begin
            in_bounds_q  <= in_bounds;
            in_bounds_q2 <= in_bounds_q;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        addr_q <= geom.base + rom_addr_t'(texel_index >> 2);
        sel_q  <= texel_index[1:0];   // low texel first
        sel_q2 <= sel_q;
    end

    // stage 2 is the registered ROM read
    sprite_rom u_rom (
        .clk_25MHz (clk_25MHz),
        .addr      (addr_q),
        .data      (rom_data)
    );

    assign texel        = rom_data[{sel_q2, 1'b0} +: 2];
    assign result.texel = texel;
    assign result.hit   = in_bounds_q2 && (texel != TEXEL_CLEAR);

endmodule

// File: logic/pixel_compositor.sv
/*
 * pixel compositor
 * lowest-index opaque lane wins, else background bands; registered output
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module pixel_compositor import render_pkg::*; (
    input  logic         clk_25MHz,
    input  logic         arst_n,
    input  coord_t       h_cnt,
    input  coord_t       v_cnt,
    input  lane_result_t results [`RENDER_NUM_OBJECTS],
    output colour_t      pixel
);

    localparam int DELAY = `RENDER_PIPE_LATENCY - 1;   // match the lanes

    coord_t  h_pipe [DELAY];
    coord_t  v_pipe [DELAY];
    coord_t  h_d;
    coord_t  v_d;
    logic    sprite_hit;
    texel_t  sprite_texel;
    colour_t next_pixel;

    always_ff @(posedge clk_25MHz) begin
        h_pipe[0] <= h_cnt;
        v_pipe[0] <= v_cnt;
        for (int i = 1; i < DELAY; i++) begin
            h_pipe[i] <= h_pipe[i-1];
            v_pipe[i] <= v_pipe[i-1];
        end
    end

    assign h_d = h_pipe[DELAY-1];
    assign v_d = v_pipe[DELAY-1];

    always_comb begin
        sprite_hit   = 1'b0;
        sprite_texel = TEXEL_CLEAR;
        // walk down so slot 0 ends up on top
        for (int i = `RENDER_NUM_OBJECTS - 1; i >= 0; i--) begin
            if (results[i].hit) begin
                sprite_hit   = 1'b1;
                sprite_texel = results[i].texel;
            end
        end

        if (h_d >= `RENDER_H_ACTIVE || v_d >= `RENDER_V_ACTIVE) begin
            next_pixel = 12'h000;                       // blanking
        end else if (v_d >= `RENDER_FIELD_BOTTOM) begin
            next_pixel = `RENDER_COLOUR_BOARD;
        end else if (sprite_hit) begin
            case (sprite_texel)
                TEXEL_LIGHT:  next_pixel = `RENDER_COLOUR_LIGHT;
                TEXEL_ACCENT: next_pixel = `RENDER_COLOUR_ACCENT;
                default:      next_pixel = `RENDER_COLOUR_DARK;
            endcase
        end else if (v_d >= `RENDER_PATH_TOP && v_d < `RENDER_PATH_BOTTOM) begin
            next_pixel = `RENDER_COLOUR_PATH;
        end else if (v_d >= `RENDER_GRASS_TOP) begin
            next_pixel = `RENDER_COLOUR_GRASS;
        end else begin
            next_pixel = `RENDER_COLOUR_SKY;
        end
    end

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            pixel <= '0;
        end else begin
            pixel <= next_pixel;
        end
    end

endmodule

// File: logic/battlefield_renderer.sv
/*
 * battlefield renderer top
 * object table feeding one sprite lane per slot, merged by the compositor
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module battlefield_renderer import render_pkg::*; (
    input  logic                                  clk_25MHz,
    input  logic                                  arst_n,
    input  coord_t                                h_cnt,
    input  coord_t                                v_cnt,
    input  logic                                  obj_req,
    input  logic [$clog2(`RENDER_NUM_OBJECTS)-1:0] obj_index,
    input  object_t                               obj_data,
    output logic                                  obj_ack,
    output colour_t                               pixel
);

    object_t      objects [`RENDER_NUM_OBJECTS];
    lane_result_t results [`RENDER_NUM_OBJECTS];

    object_table u_table (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .obj_req   (obj_req),
        .obj_index (obj_index),
        .obj_data  (obj_data),
        .obj_ack   (obj_ack),
        .objects   (objects)
    );

    for (genvar i = 0; i < `RENDER_NUM_OBJECTS; i++) begin : g_lane
        sprite_lane u_lane (
            .clk_25MHz (clk_25MHz),
            .arst_n    (arst_n),
            .h_cnt     (h_cnt),
            .v_cnt     (v_cnt),
            .object    (objects[i]),
            .result    (results[i])
        );
    end

    pixel_compositor u_compositor (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .results   (results),
        .pixel     (pixel)
    );

endmodule

// File: verif/battlefield_renderer_properties.sv
/*
 * object table handshake assertions
 * reset state and four-phase req/ack ordering
 */
`timescale 1ns/1ns

module battlefield_renderer_properties (
    input logic clk_25MHz,
    input logic arst_n,
    input logic obj_req,
    input logic obj_ack
);

    int unsigned failures = 0;   // failed assertions so far

    ack_reset: assert property (@(posedge clk_25MHz) !arst_n |-> !obj_ack)
        else begin
            failures++;
            $error("obj_ack high while reset is asserted");
        end

    ack_needs_req: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        $rose(obj_ack) |-> $past(obj_req))
        else begin
            failures++;
            $error("obj_ack rose without a pending obj_req");
        end

    // one cycle release
    ack_release: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        obj_ack && !obj_req |=> !obj_ack)
        else begin
            failures++;
            $error("obj_ack did not fall one cycle after obj_req dropped");
        end

    req_held: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        $fell(obj_req) |-> obj_ack)
        else begin
            failures++;
            $error("obj_req dropped before obj_ack was given");
        end

endmodule

// File: verif/battlefield_renderer_tb.sv
/*
 * battlefield renderer testbench
 * directed tests checked against a model of the sprite and band rules
 */
`timescale 1ns/1ns
`include "render_cfg.svh"

module battlefield_renderer_tb import render_pkg::*; ();

    localparam int LATENCY = `RENDER_PIPE_LATENCY;
    localparam int TIMEOUT = 20;

    logic                                   clk_25MHz;
    logic                                   arst_n;
    coord_t                                 h_cnt;
    coord_t                                 v_cnt;
    logic                                   obj_req;
    logic [$clog2(`RENDER_NUM_OBJECTS)-1:0] obj_index;
    object_t                                obj_data;
    logic                                   obj_ack;
    colour_t                                pixel;

    object_t     ref_obj [`RENDER_NUM_OBJECTS];
    logic [7:0]  ref_rom [`RENDER_ROM_DEPTH];
    colour_t     exp_q [$];
    string       name_q [$];
    logic [15:0] lfsr = 16'd23;
    int          checks = 0;
    int          errors = 0;

    always #20 clk_25MHz = ~clk_25MHz;

    battlefield_renderer dut (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .obj_req   (obj_req),
        .obj_index (obj_index),
        .obj_data  (obj_data),
        .obj_ack   (obj_ack),
        .pixel     (pixel)
    );

    bind object_table battlefield_renderer_properties u_props (
        .clk_25MHz (clk_25MHz),
        .arst_n    (arst_n),
        .obj_req   (obj_req),
        .obj_ack   (obj_ack)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic int unsigned random_bits(input int n);
        int unsigned value;
        logic        fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = (value << 1) | fb;
        end
        return value;
    endfunction

    function automatic colour_t expected_colour(input int h, input int v);
        int w;
        int ht;
        int base;
        int dx;
        int dy;
        int idx;
        int code;
        if (v >= `RENDER_FIELD_BOTTOM) return `RENDER_COLOUR_BOARD;
        for (int i = 0; i < `RENDER_NUM_OBJECTS; i++) begin   // slot 0 first
            base = (ref_obj[i].kind == 3'd1) ? 32 : 0;
            w    = (ref_obj[i].kind <= 3'd1) ? 8 : 0;
            ht   = (ref_obj[i].kind == 3'd0) ? 8 : 4;
            dx   = h - int'(ref_obj[i].x);
            dy   = v - int'(ref_obj[i].y);
            if (ref_obj[i].exists && dx >= 0 && dy >= 0 && dx < 2 * w && dy < 2 * ht) begin
                idx  = (dy / 2) * w + dx / 2 + (ref_obj[i].state[0] ? w * ht : 0);
                code = (ref_rom[base + idx / 4] >> (2 * (idx % 4))) & 3;
                if (code == 0) return `RENDER_COLOUR_LIGHT;
                if (code == 2) return `RENDER_COLOUR_ACCENT;
                if (code == 1) return `RENDER_COLOUR_DARK;
            end
        end
        if (v >= `RENDER_PATH_TOP && v < `RENDER_PATH_BOTTOM) return `RENDER_COLOUR_PATH;
        if (v >= `RENDER_GRASS_TOP) return `RENDER_COLOUR_GRASS;
        return `RENDER_COLOUR_SKY;
    endfunction

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one coordinate per clock, the pixel from LATENCY steps back is checked
    task automatic step_pixel(input int h, input int v);
        @(posedge clk_25MHz);
        #2;
        if (exp_q.size() == LATENCY) check_colour(name_q.pop_front(), pixel, exp_q.pop_front());
        h_cnt = coord_t'(h);
        v_cnt = coord_t'(v);
        exp_q.push_back(expected_colour(h, v));
        name_q.push_back($sformatf("pixel(%0d,%0d)", h, v));
    endtask

    task automatic flush_pixels();
        while (exp_q.size() > 0) begin
            @(posedge clk_25MHz);
            #2;
            check_colour(name_q.pop_front(), pixel, exp_q.pop_front());
        end
    endtask

    task automatic scan_box(input int x0, input int y0, input int w, input int h);
        for (int y = y0; y < y0 + h; y++) begin
            for (int x = x0; x < x0 + w; x++) begin
                step_pixel(x, y);
            end
        end
        flush_pixels();
    endtask

    task automatic write_object(input int slot, input object_t obj);
        int cycles;
        @(posedge clk_25MHz);
        #2;
        check_ack("obj_ack", obj_ack, 1'b0);   // must be idle before req
        obj_index = 2'(slot);
        obj_data  = obj;
        obj_req   = 1'b1;
        cycles    = 0;
        do begin
            @(posedge clk_25MHz);
            #2;
            cycles++;
        end while (!obj_ack && cycles < TIMEOUT);
        if (!obj_ack) begin
            errors++;
            $display("obj_ack never rose for slot %0d within %0d cycles", slot, TIMEOUT);
        end else if (cycles != 1) begin
            errors++;
            $display("obj_ack rose %0d cycles after req instead of 1", cycles);
        end
        ref_obj[slot] = obj;
        obj_req = 1'b0;
        cycles  = 0;
        do begin
            @(posedge clk_25MHz);
            #2;
            cycles++;
        end while (obj_ack && cycles < TIMEOUT);
        if (obj_ack) begin
            errors++;
            $display("obj_ack stayed high for slot %0d after req dropped", slot);
        end else if (cycles != 1) begin
            errors++;
            $display("obj_ack fell %0d cycles after req dropped instead of 1", cycles);
        end
    endtask

    task automatic reset_state_and_bands();
        int rows [8] = '{139, 140, 169, 170, 229, 230, 269, 270};
        check_ack("obj_ack", obj_ack, 1'b0);
        check_colour("pixel", pixel, 12'h000);
        for (int i = 0; i < 200; i++) begin
            step_pixel(random_bits(10) % 640, random_bits(9) % 480);
        end
        foreach (rows[i]) step_pixel(random_bits(10) % 640, rows[i]);
        flush_pixels();
    endtask

    task automatic write_all_slots();
        for (int s = 0; s < `RENDER_NUM_OBJECTS; s++) begin
            write_object(s, '{exists: 1'b0, kind: 3'(s), x: coord_t'(40 * s),
                              y: coord_t'(150), state: 4'h0});
        end
        scan_box(0, 146, 140, 6);   // empty slots draw nothing
    endtask

    task automatic draw_kind0_sprite();
        int x;
        int y;
        x = 2 + random_bits(10) % 590;
        y = 2 + random_bits(8) % 240;
        write_object(0, '{exists: 1'b1, kind: 3'd0, x: coord_t'(x), y: coord_t'(y), state: 4'h0});
        scan_box(x - 2, y - 2, 20, 20);
    endtask

    task automatic frame_kind_and_exists();
        int x;
        int y;
        x = 2 + random_bits(10) % 590;
        y = 2 + random_bits(8) % 240;
        write_object(1, '{exists: 1'b1, kind: 3'd0, x: coord_t'(x), y: coord_t'(y), state: 4'h1});
        scan_box(x - 2, y - 2, 20, 20);
        write_object(1, '{exists: 1'b1, kind: 3'd1, x: coord_t'(x), y: coord_t'(y), state: 4'h0});
        scan_box(x - 2, y - 2, 20, 12);
        write_object(1, '{exists: 1'b1, kind: 3'd1, x: coord_t'(x), y: coord_t'(y), state: 4'h1});
        scan_box(x - 2, y - 2, 20, 12);
        write_object(1, '{exists: 1'b0, kind: 3'd1, x: coord_t'(x), y: coord_t'(y), state: 4'h1});
        scan_box(x - 2, y - 2, 20, 20);
    endtask

    // army slot 0 over two enemies, crossing the grass to path edge
    task automatic overlap_priority();
        write_object(0, '{exists: 1'b1, kind: 3'd0, x: 10'd300, y: 10'd150, state: 4'h0});
        write_object(2, '{exists: 1'b1, kind: 3'd0, x: 10'd304, y: 10'd156, state: 4'h1});
        write_object(3, '{exists: 1'b1, kind: 3'd1, x: 10'd296, y: 10'd160, state: 4'h0});
        scan_box(292, 146, 30, 30);
    endtask

    initial begin
        clk_25MHz = 1'b0;
        arst_n    = 1'b1;
        h_cnt     = '0;
        v_cnt     = '0;
        obj_req   = 1'b0;
        obj_index = '0;
        obj_data  = '0;
        foreach (ref_obj[i]) ref_obj[i] = '0;
        $readmemh("sprites.mem", ref_rom);
        #1;
        arst_n = 1'b0;
        repeat (5) @(posedge clk_25MHz);
        #2;
        arst_n = 1'b1;
        reset_state_and_bands();
        write_all_slots();
        draw_kind0_sprite();
        frame_kind_and_exists();
        overlap_priority();
        errors += dut.u_table.u_props.failures;
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sprites.mem
// one byte per line, four 2-bit texels, texel 0 in bits 1:0 (3 is transparent)
// bytes 00-1f kind 0 frames 0 and 1, 20-2f kind 1 frames 0 and 1, rest unused
0f
f0
03
c0
93
c6
01
40
a3
ca
0f
f0
4f
f1
7f
fd
0f
f0
03
c0
63
c9
01
40
3a
ac
0f
f0
f1
4f
fd
7f
3f
fc
24
18
00
00
73
cd
3f
fc
18
24
55
55
cd
73
e4
1b
4e
b1
e4
1b
4e
b1
ff
00
ff
00
aa
55
aa
55

// File: sources.f
+incdir+include
logic/render_pkg.sv
logic/object_table.sv
logic/sprite_rom.sv
logic/sprite_lane.sv
logic/pixel_compositor.sv
logic/battlefield_renderer.sv
verif/battlefield_renderer_properties.sv
verif/battlefield_renderer_tb.sv

// File: Bender.yml
package:
  name: battlefield_renderer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/render_pkg.sv
      - logic/object_table.sv
      - logic/sprite_rom.sv
      - logic/sprite_lane.sv
      - logic/pixel_compositor.sv
      - logic/battlefield_renderer.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/battlefield_renderer_properties.sv
      - verif/battlefield_renderer_tb.sv
